//--- filelist.f
src/rx_pkt_pkg.sv
src/drain_ctrl_if.sv
src/pkt_word_buffer.sv
src/symbol_counter.sv
src/frame_sequencer.sv
src/byte_emitter.sv
src/rx_pkt_serializer.sv
dv/tb_rx_pkt_serializer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the serializer testbench with verilator
# exit status is 0 only when the pass message is printed

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f filelist.f --top-module tb_rx_pkt_serializer -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_rx_pkt_serializer)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "all tests passed"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1

//--- dv/tb_rx_pkt_serializer.sv
/*
 * testbench for the receive packet serializer
 * packet table applied in a loop, byte stream model built from
 * the framing rules, immediate checks and a cycle watchdog
 */
`timescale 1ns/10ps

module tb_rx_pkt_serializer;
	import rx_pkt_pkg::*;

	typedef struct {
		string name;
		int    start;     // first word address
		int    nwords;    // 0 for an empty packet
		strb_t last_strb; // strobe of the last word
		int    exp_len;   // bytes expected at the output
	} row_t;

	localparam byte_t TAIL [5] = '{8'hC1, 8'hC2, 8'hC3, 8'hC4, 8'hFD};

	logic     rx_mac_aclk;
	logic     reset;
	logic     rx_axis_mac_tvalid;
	logic     rd_done;
	addr_t    mem_rd_address;
	word_t    mem_axis_rdata;
	strb_t    mem_axis_rstrb;
	byte_t    byte_out;
	logic     ctrl_out;
	logic     byte_valid;
	logic     busy;
	pkt_cnt_t pkt_cnt;

	row_t   rows [$];
	integer seed;
	int     errors = 0;
	int     checks = 0;
	int     cycle_cnt = 0;
	int     cycle_limit;
	word_t  pkt_word [$]; // packet in flight
	strb_t  pkt_strb [$];
	byte_t  exp_byte [$];
	logic   exp_ctrl [$];

	rx_pkt_serializer i_rx_pkt_serializer (.*);

	initial begin
		rx_mac_aclk = 1'b0;
		forever #4 rx_mac_aclk = ~rx_mac_aclk;
	end

	// watchdog limit comes from the table
	initial begin
		@(posedge rx_mac_aclk);
		while (cycle_cnt < cycle_limit) begin
			@(posedge rx_mac_aclk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
		$display("tests failed");
		$finish;
	end

	task automatic add_row(input string name, input int start, input int nw,
	                       input strb_t last, input int len);
		rows.push_back('{name, start, nw, last, len});
	endtask

	task automatic compare_value(input string test, input string what,
	                             input int exp, input int act);
		checks++;
		assert (exp == act) else begin
			errors++;
			$display("MISMATCH %s %s expected %0h actual %0h", test, what, exp, act);
		end
	endtask

	task automatic expect_true(input string test, input bit cond, input string msg);
		checks++;
		assert (cond) else begin
			errors++;
			$display("ERROR %s: %s", test, msg);
		end
	endtask

	// a last word keeps only a nonzero run of low lanes
	function automatic int lane_count(input strb_t s);
		int n = 0;
		if (s != 8'd0 && ((s & (s + 8'd1)) == 8'd0)) begin
			for (int i = 0; i < 8; i++) begin
				if (s[i]) n++;
			end
		end
		return n;
	endfunction

	task automatic build_model(input int nw, input strb_t last);
		int lanes;
		exp_byte.delete();
		exp_ctrl.delete();
		for (int i = 0; i < 8; i++) begin // FB, six 55, D5
			exp_byte.push_back(i == 0 ? 8'hFB : (i == 7 ? 8'hD5 : 8'h55));
			exp_ctrl.push_back(i == 0);
		end
		if (nw > 0) begin // empty packet stops after the preamble
			for (int w = 0; w < nw; w++) begin
				lanes = (w < nw - 1) ? 8 : lane_count(last);
				for (int l = 0; l < lanes; l++) begin
					exp_byte.push_back(pkt_word[w][8*l +: 8]); // little endian
					exp_ctrl.push_back(pkt_strb[w][l]);
				end
			end
			for (int i = 0; i < 5; i++) begin
				exp_byte.push_back(TAIL[i]);
				exp_ctrl.push_back(1'b0);
			end
		end
	endtask

	// called on a falling edge and returns on one
	task automatic write_packet(input row_t r);
		word_t w;
		strb_t s;
		pkt_word.delete();
		pkt_strb.delete();
		for (int i = 0; i < r.nwords; i++) begin
			w = {$random(seed), $random(seed)};
			s = (i == r.nwords - 1) ? r.last_strb : strb_t'($random(seed)); // inner strobes only set ctrl
			pkt_word.push_back(w);
			pkt_strb.push_back(s);
			rx_axis_mac_tvalid = 1'b1;
			mem_rd_address = addr_t'(r.start + i);
			mem_axis_rdata = w;
			mem_axis_rstrb = s;
			@(negedge rx_mac_aclk);
		end
		rx_axis_mac_tvalid = 1'b0;
	endtask

	task automatic drain_packet(input row_t r, input int num);
		byte_t got_byte [$];
		logic  got_ctrl [$];
		@(negedge rx_mac_aclk); // idle gap after the writes
		expect_true(r.name, !busy && !byte_valid, "busy or byte_valid high between packets");
		rd_done = 1'b1;
		mem_rd_address = addr_t'(r.start + r.nwords); // end address
		@(negedge rx_mac_aclk);
		expect_true(r.name, byte_valid, "no byte in the cycle after rd_done");
		compare_value(r.name, "pkt_cnt", num, int'(pkt_cnt));
		rd_done = 1'b0;
		while (byte_valid) begin
			expect_true(r.name, busy, "busy low while bytes are sent");
			got_byte.push_back(byte_out);
			got_ctrl.push_back(ctrl_out);
			@(negedge rx_mac_aclk);
		end
		expect_true(r.name, !busy, "busy still high after the last byte");
		build_model(r.nwords, r.last_strb);
		compare_value(r.name, "byte count", exp_byte.size(), got_byte.size());
		compare_value(r.name, "table byte count", r.exp_len, got_byte.size());
		for (int i = 0; i < exp_byte.size() && i < got_byte.size(); i++) begin
			compare_value(r.name, $sformatf("byte %0d", i), int'(exp_byte[i]), int'(got_byte[i]));
			compare_value(r.name, $sformatf("ctrl %0d", i), int'(exp_ctrl[i]), int'(got_ctrl[i]));
		end
	endtask

	initial begin
		seed = 32'h5450;
		reset = 1'b1;
		rx_axis_mac_tvalid = 1'b0;
		rd_done = 1'b0;
		mem_rd_address = '0;
		mem_axis_rdata = '0;
		mem_axis_rstrb = '0;
		add_row("one_word_full",   0,    1,  8'hFF, 21);
		add_row("multi_word_full", 16,   4,  8'hFF, 45);
		add_row("strb_01",         40,   2,  8'h01, 22);
		add_row("strb_03",         50,   1,  8'h03, 15);
		add_row("strb_07",         60,   3,  8'h07, 32);
		add_row("strb_0f",         70,   1,  8'h0F, 17);
		add_row("strb_1f",         80,   2,  8'h1F, 26);
		add_row("strb_3f",         90,   1,  8'h3F, 19);
		add_row("strb_7f",         100,  2,  8'h7F, 28);
		add_row("holes_05",        120,  2,  8'h05, 21);
		add_row("high_only_80",    130,  1,  8'h80, 13);
		add_row("empty",           130,  0,  8'h00, 8);  // start equals the last packet's start
		add_row("near_top",        2040, 7,  8'hFF, 69);
		add_row("long_pkt",        200,  16, 8'h3F, 139);
		cycle_limit = 200;
		foreach (rows[i]) begin
			cycle_limit += rows[i].nwords + rows[i].exp_len + 10;
		end
		repeat (10) @(negedge rx_mac_aclk);
		reset = 1'b0;
		@(negedge rx_mac_aclk);
		expect_true("reset", !byte_valid && !busy && pkt_cnt == '0, "outputs not clear after reset");
		foreach (rows[i]) begin
			write_packet(rows[i]);
			drain_packet(rows[i], i + 1);
		end
		compare_value("summary", "pkt_cnt", rows.size(), int'(pkt_cnt));
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- src/rx_pkt_serializer.sv
/*
 * receive packet capture and byte serializer, top level
 * word buffer, drain sequencer, symbol counter and byte mux
 * joined by the drain control bundle
 */
`timescale 1ns/10ps

module rx_pkt_serializer (
	input  logic                 rx_mac_aclk,
	input  logic                 reset,
	input  logic                 rx_axis_mac_tvalid, // write enable
	input  rx_pkt_pkg::addr_t    mem_rd_address,     // write address, end on rd_done
	input  rx_pkt_pkg::word_t    mem_axis_rdata,
	input  rx_pkt_pkg::strb_t    mem_axis_rstrb,
	input  logic                 rd_done,
	output rx_pkt_pkg::byte_t    byte_out,
	output logic                 ctrl_out,
	output logic                 byte_valid,
	output logic                 busy,
	output rx_pkt_pkg::pkt_cnt_t pkt_cnt
);
	import rx_pkt_pkg::*;

	word_t rd_word;    // buffer read data
	strb_t rd_strb;
	addr_t start_addr; // packet start from the buffer

	drain_ctrl_if ctl ();

	pkt_word_buffer i_pkt_word_buffer (
		.rx_mac_aclk (rx_mac_aclk),
		.reset       (reset),
		.wr_en       (rx_axis_mac_tvalid),
		.wr_addr     (mem_rd_address),
		.wr_word     (mem_axis_rdata),
		.wr_strb     (mem_axis_rstrb),
		.rd_addr     (ctl.rd_addr),
		.rd_word     (rd_word),
		.rd_strb     (rd_strb),
		.start_addr  (start_addr)
	);

	frame_sequencer i_frame_sequencer (
		.rx_mac_aclk    (rx_mac_aclk),
		.reset          (reset),
		.ctl            (ctl.seq),
		.rd_done        (rd_done),
		.mem_rd_address (mem_rd_address),
		.start_addr     (start_addr),
		.busy           (busy),
		.pkt_cnt        (pkt_cnt)
	);

	symbol_counter i_symbol_counter (
		.rx_mac_aclk (rx_mac_aclk),
		.reset       (reset),
		.ctl         (ctl.cnt),
		.start_addr  (start_addr),
		.end_addr    (mem_rd_address), // latched on the accepted rd_done
		.rd_strb     (rd_strb)
	);

	byte_emitter i_byte_emitter (
		.ctl        (ctl.emit),
		.rd_word    (rd_word),
		.rd_strb    (rd_strb),
		.byte_out   (byte_out),
		.ctrl_out   (ctrl_out),
		.byte_valid (byte_valid)
	);

endmodule

//--- src/byte_emitter.sv
/*
 * output byte mux
 * framing constants in preamble and trailer, indexed lane and its
 * strobe bit in payload, byte_valid for every non-idle cycle
 */
`timescale 1ns/10ps

module byte_emitter (
	drain_ctrl_if.emit        ctl,
	input  rx_pkt_pkg::word_t rd_word,
	input  rx_pkt_pkg::strb_t rd_strb,
	output rx_pkt_pkg::byte_t byte_out,
	output logic              ctrl_out,   // strobe bit or start marker
	output logic              byte_valid
);
	import rx_pkt_pkg::*;

	logic [2:0] sel;       // lane or table index
	logic       tail_skip; // last word has no usable lanes

	assign sel       = ctl.sym_idx[2:0];
	assign tail_skip = ctl.is_last_word && (last_word_bytes(rd_strb) == 4'd0);

	always_comb begin
		byte_out = '0;
		ctrl_out = 1'b0;
		case (ctl.state)
			ST_PREAMBLE: begin
				if (ctl.sym_idx == 4'd0) begin
					byte_out = SOF_BYTE;
					ctrl_out = 1'b1; // only control byte of the frame
				end else if (ctl.sym_idx == 4'(PREAMBLE_LEN - 1)) begin
					byte_out = SFD_BYTE;
				end else begin
					byte_out = PRE_BYTE;
				end
			end
			ST_PAYLOAD: begin
				if (tail_skip) begin
					byte_out = TRAILER_BYTES[0]; // trailer pulled in, keeps the stream dense
				end else begin
					byte_out = rd_word[{sel, 3'b000} +: 8]; // little endian lanes
					ctrl_out = rd_strb[sel];
				end
			end
			ST_TRAILER: begin
				byte_out = TRAILER_BYTES[sel];
			end
			default: begin
				byte_out = '0;
				ctrl_out = 1'b0;
			end
		endcase
	end

	assign byte_valid = (ctl.state != ST_IDLE); // no gaps inside a frame

endmodule

//--- src/frame_sequencer.sv
/*
 * drain state machine and packet counter
 * idle, preamble, payload and trailer steps on phase_last,
 * holds the end address and counts accepted rd_done pulses
 */
`timescale 1ns/10ps

module frame_sequencer (
	input  logic                 rx_mac_aclk,
	input  logic                 reset,
	drain_ctrl_if.seq            ctl,
	input  logic                 rd_done,        // one clock start pulse
	input  rx_pkt_pkg::addr_t    mem_rd_address, // end of the stored packet
	input  rx_pkt_pkg::addr_t    start_addr,
	output logic                 busy,
	output rx_pkt_pkg::pkt_cnt_t pkt_cnt
);
	import rx_pkt_pkg::*;

	drain_state_t state_q;
	drain_state_t state_d;
	addr_t        end_q;     // end address for this drain
	logic         start;     // rd_done taken
	logic         pkt_empty; // no words between start and end

	assign start     = (state_q == ST_IDLE) && rd_done; // ignored while busy
	assign pkt_empty = (start_addr == end_q);

	assign ctl.state    = state_q;
	assign ctl.first_rd = start;
	assign busy         = (state_q != ST_IDLE);

	// next state
	// payload lanes of a bad last strobe are folded away by the counter,
	// which ends the payload phase on that word's first cycle
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (rd_done) begin
					state_d = ST_PREAMBLE;
				end
			end
			ST_PREAMBLE: begin
				if (ctl.phase_last) begin
					state_d = pkt_empty ? ST_IDLE : ST_PAYLOAD; // empty packet, no trailer
				end
			end
			ST_PAYLOAD: begin
				if (ctl.phase_last) begin
					state_d = ST_TRAILER;
				end
			end
			ST_TRAILER: begin
				if (ctl.phase_last) begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge rx_mac_aclk) begin
		if (reset) begin
			state_q <= ST_IDLE;
			end_q   <= '0;
			pkt_cnt <= '0;
		end else begin
			state_q <= state_d;
			if (start) begin
				end_q   <= mem_rd_address; // tvalid is low by now
				pkt_cnt <= pkt_cnt + pkt_cnt_t'(1); // visible with the first byte
			end
		end
	end

	// a start pulse during a drain would be lost
	a_no_start_busy: assert property (
		@(posedge rx_mac_aclk) disable iff (reset)
		busy |-> !rd_done
	) else $error("rd_done while a packet is still draining");

	// the last word always closes with the trailer
	a_last_to_trailer: assert property (
		@(posedge rx_mac_aclk) disable iff (reset)
		(state_q == ST_PAYLOAD && ctl.phase_last) |-> ctl.is_last_word
	) else $error("payload ended before the last word");

endmodule

//--- src/symbol_counter.sv
/*
 * per-phase symbol counter and word address stepper
 * raises phase_last at the end of preamble, payload and trailer,
 * presents each word address one clock ahead of its lanes
 */
`timescale 1ns/10ps

module symbol_counter (
	input  logic              rx_mac_aclk,
	input  logic              reset,
	drain_ctrl_if.cnt         ctl,
	input  rx_pkt_pkg::addr_t start_addr,
	input  rx_pkt_pkg::addr_t end_addr,   // one past the last word
	input  rx_pkt_pkg::strb_t rd_strb
);
	import rx_pkt_pkg::*;

	logic [3:0] idx_q;      // symbol within the phase
	addr_t      word_ptr;   // word now on the read port
	addr_t      end_q;      // end address held for the drain
	logic [3:0] tail_bytes; // lanes used by the last word
	logic       is_last;
	logic       tail_skip;  // bad last strobe gives no lanes
	logic       word_step;  // move to the next word on lane 7
	logic       phase_last;

	assign tail_bytes = last_word_bytes(rd_strb);
	assign is_last    = (word_ptr == end_q - addr_t'(1));
	assign tail_skip  = is_last && (tail_bytes == 4'd0);
	assign word_step  = (ctl.state == ST_PAYLOAD) && (idx_q == 4'(LANES - 1)) && !is_last;

	always_comb begin
		case (ctl.state)
			ST_PREAMBLE: phase_last = (idx_q == 4'(PREAMBLE_LEN - 1));
			// only the last word can close the payload
			ST_PAYLOAD:  phase_last = is_last && (tail_skip || idx_q == tail_bytes - 4'd1);
			ST_TRAILER:  phase_last = (idx_q == 4'(TRAILER_LEN - 1));
			default:     phase_last = 1'b0;
		endcase
	end

	assign ctl.sym_idx      = idx_q;
	assign ctl.phase_last   = phase_last;
	assign ctl.is_last_word = is_last;
	assign ctl.rd_addr      = word_step ? word_ptr + addr_t'(1) : word_ptr; // look ahead

	always_ff @(posedge rx_mac_aclk) begin
		if (reset) begin
			idx_q    <= '0;
			word_ptr <= '0;
			end_q    <= '0;
		end else begin
			if (ctl.first_rd) begin
				word_ptr <= start_addr; // read starts during preamble
				end_q    <= end_addr;
			end else if (word_step) begin
				word_ptr <= word_ptr + addr_t'(1);
			end
			if (ctl.state == ST_IDLE) begin
				idx_q <= '0;
			end else if (phase_last || word_step) begin
				// lane 7 of an inner word wraps to lane 0
				// a skipped last word already sent the first trailer byte
				idx_q <= (ctl.state == ST_PAYLOAD && tail_skip) ? 4'd1 : 4'd0;
			end else begin
				idx_q <= idx_q + 4'd1;
			end
		end
	end

	a_rd_below_end: assert property (
		@(posedge rx_mac_aclk) disable iff (reset)
		(ctl.state == ST_PAYLOAD) |-> (ctl.rd_addr < end_q)
	) else $error("payload read past the packet end");

endmodule

//--- src/pkt_word_buffer.sv
/*
 * receive word buffer
 * word and strobe memories written while wr_en is high,
 * registered read port, start address capture on wr_en rise
 */
`timescale 1ns/10ps

module pkt_word_buffer (
	input  logic              rx_mac_aclk,
	input  logic              reset,
	input  logic              wr_en,      // rx tvalid
	input  rx_pkt_pkg::addr_t wr_addr,
	input  rx_pkt_pkg::word_t wr_word,
	input  rx_pkt_pkg::strb_t wr_strb,
	input  rx_pkt_pkg::addr_t rd_addr,
	output rx_pkt_pkg::word_t rd_word,    // valid one clock after rd_addr
	output rx_pkt_pkg::strb_t rd_strb,
	output rx_pkt_pkg::addr_t start_addr  // first address of the latest packet
);
	import rx_pkt_pkg::*;

	word_t mem_word [DEPTH];
	strb_t mem_strb [DEPTH];

	logic  wr_en_q; // previous tvalid for rise detect

	// write port
	// data and strobe share the address so they stay paired
	always_ff @(posedge rx_mac_aclk) begin
		if (wr_en) begin
			mem_word[wr_addr] <= wr_word;
			mem_strb[wr_addr] <= wr_strb;
		end
	end

	// free running read port
	// the counter holds rd_addr steady when no step is needed
	always_ff @(posedge rx_mac_aclk) begin
		rd_word <= mem_word[rd_addr]; // old data on a same-address write
		rd_strb <= mem_strb[rd_addr];
	end

	// start of packet
	// first valid word after an idle gap marks the packet start
	always_ff @(posedge rx_mac_aclk) begin
		if (reset) begin
			wr_en_q    <= 1'b0;
			start_addr <= '0;
		end else begin
			wr_en_q <= wr_en;
			if (wr_en && !wr_en_q) begin
				start_addr <= wr_addr; // held until the next packet begins
			end
		end
	end

	// packet words sit at consecutive addresses for the drain
	a_wr_contiguous: assert property (
		@(posedge rx_mac_aclk) disable iff (reset)
		(wr_en && wr_en_q) |-> (wr_addr == $past(wr_addr) + addr_t'(1))
	) else $error("packet words not written to consecutive addresses");

endmodule

//--- src/drain_ctrl_if.sv
/*
 * drain control bundle
 * state and start strobe from the sequencer, symbol index,
 * phase end flag and word read address from the counter
 */
`timescale 1ns/10ps

interface drain_ctrl_if;
	import rx_pkt_pkg::*;

	drain_state_t state;        // current drain phase
	logic [3:0]   sym_idx;      // preamble/trailer index, lane in payload
	logic         phase_last;   // final symbol of this phase
	addr_t        rd_addr;      // buffer read address
	logic         is_last_word; // word on rd_word is the packet's last
	logic         first_rd;     // accepted rd_done, loads the counter

	// sequencer side
	modport seq (
		output state, first_rd,
		input  sym_idx, phase_last, rd_addr, is_last_word
	);

	// counter and address side
	modport cnt (
		output sym_idx, phase_last, rd_addr, is_last_word,
		input  state, first_rd
	);

	// byte mux only looks
	modport emit (
		input state, sym_idx, phase_last, rd_addr, is_last_word, first_rd
	);

endinterface

//--- src/rx_pkt_pkg.sv
/*
 * shared definitions for the receive packet serializer
 * buffer widths and depth, framing byte constants,
 * the drain sequencer state type and the last-word strobe decoder
 */

package rx_pkt_pkg;

	localparam int ADDR_W       = 11;            // buffer address bits
	localparam int DEPTH        = 1 << ADDR_W;   // 2048 words
	localparam int WORD_W       = 64;            // receive word
	localparam int STRB_W       = 8;             // one strobe bit per lane
	localparam int LANES        = 8;             // bytes per word
	localparam int PREAMBLE_LEN = 8;
	localparam int TRAILER_LEN  = 5;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [7:0]        byte_t;
	typedef logic [31:0]       pkt_cnt_t;

	localparam byte_t SOF_BYTE = 8'hFB;          // start of frame, ctrl set
	localparam byte_t PRE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE = 8'hD5;

	// fixed tail sent after the payload
	localparam byte_t TRAILER_BYTES [TRAILER_LEN] = '{8'hC1, 8'hC2, 8'hC3, 8'hC4, 8'hFD};

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_PAYLOAD,
		ST_TRAILER
	} drain_state_t;

	// bytes carried by the last word of a packet
	// only a contiguous run of low lanes counts, anything else gives 0
	function automatic logic [3:0] last_word_bytes(input strb_t strb);
		case (strb)
			8'h01:   return 4'd1;
			8'h03:   return 4'd2;
			8'h07:   return 4'd3;
			8'h0F:   return 4'd4;
			8'h1F:   return 4'd5;
			8'h3F:   return 4'd6;
			8'h7F:   return 4'd7;
			8'hFF:   return 4'd8;
			default: return 4'd0; // holes or high lanes only
		endcase
	endfunction

endpackage
